// File: flist.f
source/emif_bridge_pkg.sv
source/axi_reg_slice.sv
source/emif_write_path.sv
source/emif_read_path.sv
source/emif_bridge.sv
bench/emif_bridge_checker.sv
bench/tb_emif_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_emif_bridge \
    -Mdir obj_dir \
    -o tb_emif_bridge \
    -f flist.f

./obj_dir/tb_emif_bridge | tee sim.log

if grep -q "^PASS: all tests$" sim.log; then
    echo "run_sim: simulation passed"
    exit 0
else
    echo "run_sim: simulation failed"
    exit 1
fi

// File: bench/tb_emif_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_emif_bridge;
    import emif_bridge_pkg::*;

    localparam int CLK_PERIOD     = 8;
    localparam int N_AW           = 1500;
    localparam int N_W            = 1000;
    localparam int N_AR           = 1500;
    localparam int TIMEOUT_CYCLES = (N_AW + N_W + N_AR) * 20;

    logic    s_if;
    logic    rst;
    aw_req_t usr_aw;
    logic    usr_aw_valid;
    logic    usr_aw_ready;
    w_beat_t usr_w;
    logic    usr_w_valid;
    logic    usr_w_ready;
    b_resp_t usr_b;
    logic    usr_b_valid;
    logic    usr_b_ready;
    ar_req_t usr_ar;
    logic    usr_ar_valid;
    logic    usr_ar_ready;
    r_beat_t usr_r;
    logic    usr_r_valid;
    logic    usr_r_ready;
    aw_req_t mem_aw;
    logic    mem_aw_valid;
    logic    mem_aw_ready;
    w_beat_t mem_w;
    logic    mem_w_valid;
    logic    mem_w_ready;
    b_resp_t mem_b;
    logic    mem_b_valid;
    logic    mem_b_ready;
    ar_req_t mem_ar;
    logic    mem_ar_valid;
    logic    mem_ar_ready;
    r_beat_t mem_r;
    logic    mem_r_valid;
    logic    mem_r_ready;
    logic    idle;
    logic    drained;
    int      data_errors;
    int      flow_errors;

    // Memory model state, filled from accepted address requests
    logic [ID_WIDTH-1:0] b_ids[$];
    ar_req_t             ar_reqs[$];

    emif_bridge UUT (.*);

    emif_bridge_checker u_checker (.*);

    initial begin
        s_if = 1'b0;
        forever #(CLK_PERIOD / 2) s_if = ~s_if;
    end

    function automatic aw_req_t random_req();
        aw_req_t req;
        req.id    = ID_WIDTH'($urandom);
        req.addr  = $urandom;
        // Short bursts keep the read traffic moving
        req.len   = 8'($urandom_range(0, 3));
        req.size  = 3'($urandom);
        req.burst = 2'($urandom);
        req.lock  = 1'($urandom);
        req.cache = 4'($urandom);
        req.prot  = 3'($urandom);
        req.user  = USER_WIDTH'($urandom);
        return req;
    endfunction

    // ------------------------------------------------------------------------
    // User side drivers, handshake sampled at the falling edge
    // ------------------------------------------------------------------------
    task automatic drive_aw();
        int   sent;
        logic fire;
        sent = 0;
        while (sent < N_AW) begin
            @(negedge s_if);
            fire = usr_aw_valid && usr_aw_ready;
            @(posedge s_if);
            #1;
            if (fire) begin
                sent++;
                usr_aw_valid = 1'b0;
            end
            if (!usr_aw_valid && sent < N_AW && $urandom_range(0, 2) != 0) begin
                usr_aw       = random_req();
                usr_aw_valid = 1'b1;
            end
        end
    endtask

    task automatic drive_w();
        int   sent;
        logic fire;
        sent = 0;
        while (sent < N_W) begin
            @(negedge s_if);
            fire = usr_w_valid && usr_w_ready;
            @(posedge s_if);
            #1;
            if (fire) begin
                sent++;
                usr_w_valid = 1'b0;
            end
            if (!usr_w_valid && sent < N_W && $urandom_range(0, 2) != 0) begin
                usr_w.data  = {$urandom, $urandom};
                usr_w.strb  = STRB_WIDTH'($urandom);
                usr_w.last  = ($urandom_range(0, 3) == 0);
                usr_w_valid = 1'b1;
            end
        end
    endtask

    task automatic drive_ar();
        int   sent;
        logic fire;
        sent = 0;
        while (sent < N_AR) begin
            @(negedge s_if);
            fire = usr_ar_valid && usr_ar_ready;
            @(posedge s_if);
            #1;
            if (fire) begin
                sent++;
                usr_ar_valid = 1'b0;
            end
            if (!usr_ar_valid && sent < N_AR && $urandom_range(0, 2) != 0) begin
                usr_ar       = random_req();
                usr_ar_valid = 1'b1;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Memory side responders and random ready
    // ------------------------------------------------------------------------
    task automatic respond_b();
        logic fire;
        forever begin
            @(negedge s_if);
            fire = mem_b_valid && mem_b_ready;
            if (mem_aw_valid && mem_aw_ready) b_ids.push_back(mem_aw.id);
            @(posedge s_if);
            #1;
            if (fire) mem_b_valid = 1'b0;
            if (!mem_b_valid && b_ids.size() != 0 && $urandom_range(0, 2) != 0) begin
                mem_b.id    = b_ids.pop_front();
                mem_b.resp  = 2'($urandom);
                mem_b.user  = USER_WIDTH'($urandom);
                mem_b_valid = 1'b1;
            end
        end
    endtask

    task automatic respond_r();
        logic    fire;
        int      beats_left;
        ar_req_t cur;
        beats_left = 0;
        cur        = '0;
        forever begin
            @(negedge s_if);
            fire = mem_r_valid && mem_r_ready;
            if (mem_ar_valid && mem_ar_ready) ar_reqs.push_back(mem_ar);
            @(posedge s_if);
            #1;
            if (fire) mem_r_valid = 1'b0;
            if (!mem_r_valid && $urandom_range(0, 2) != 0) begin
                if (beats_left == 0 && ar_reqs.size() != 0) begin
                    cur        = ar_reqs.pop_front();
                    beats_left = int'(cur.len) + 1;
                end
                if (beats_left != 0) begin
                    beats_left--;
                    mem_r.id    = cur.id;
                    mem_r.data  = {$urandom, $urandom};
                    mem_r.resp  = 2'($urandom);
                    mem_r.last  = (beats_left == 0);
                    mem_r.user  = USER_WIDTH'($urandom);
                    mem_r_valid = 1'b1;
                end
            end
        end
    endtask

    task automatic drive_readies();
        forever begin
            @(posedge s_if);
            #1;
            mem_aw_ready = ($urandom_range(0, 3) != 0);
            mem_w_ready  = ($urandom_range(0, 3) != 0);
            mem_ar_ready = ($urandom_range(0, 3) != 0);
            usr_b_ready  = ($urandom_range(0, 3) != 0);
            usr_r_ready  = ($urandom_range(0, 3) != 0);
        end
    endtask

    initial begin
        rst          = 1'b1;
        usr_aw       = '0;
        usr_aw_valid = 1'b0;
        usr_w        = '0;
        usr_w_valid  = 1'b0;
        usr_b_ready  = 1'b0;
        usr_ar       = '0;
        usr_ar_valid = 1'b0;
        usr_r_ready  = 1'b0;
        mem_aw_ready = 1'b0;
        mem_w_ready  = 1'b0;
        mem_b        = '0;
        mem_b_valid  = 1'b0;
        mem_ar_ready = 1'b0;
        mem_r        = '0;
        mem_r_valid  = 1'b0;
        void'($urandom(10));

        repeat (8) @(posedge s_if);
        #1;
        rst = 1'b0;

        fork
            respond_b();
            respond_r();
            drive_readies();
        join_none

        fork
            drive_aw();
            drive_w();
            drive_ar();
        join

        // Wait for responses still in flight
        while (!drained) @(posedge s_if);
        repeat (4) @(posedge s_if);

        $display("Errors: %0d data, %0d flow", data_errors, flow_errors);
        if (data_errors == 0 && flow_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog, 20 cycles per transaction
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, queues did not drain (drained=%0b)",
                 TIMEOUT_CYCLES, drained);
        $display("Errors: %0d data, %0d flow", data_errors, flow_errors);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/emif_bridge_checker.sv
`timescale 1ns/1ps
`default_nettype none

module emif_bridge_checker (
    input  wire logic                     s_if,
    input  wire logic                     rst,
    input  wire emif_bridge_pkg::aw_req_t usr_aw,
    input  wire logic                     usr_aw_valid,
    input  wire logic                     usr_aw_ready,
    input  wire emif_bridge_pkg::w_beat_t usr_w,
    input  wire logic                     usr_w_valid,
    input  wire logic                     usr_w_ready,
    input  wire emif_bridge_pkg::b_resp_t usr_b,
    input  wire logic                     usr_b_valid,
    input  wire logic                     usr_b_ready,
    input  wire emif_bridge_pkg::ar_req_t usr_ar,
    input  wire logic                     usr_ar_valid,
    input  wire logic                     usr_ar_ready,
    input  wire emif_bridge_pkg::r_beat_t usr_r,
    input  wire logic                     usr_r_valid,
    input  wire logic                     usr_r_ready,
    input  wire emif_bridge_pkg::aw_req_t mem_aw,
    input  wire logic                     mem_aw_valid,
    input  wire logic                     mem_aw_ready,
    input  wire emif_bridge_pkg::w_beat_t mem_w,
    input  wire logic                     mem_w_valid,
    input  wire logic                     mem_w_ready,
    input  wire emif_bridge_pkg::b_resp_t mem_b,
    input  wire logic                     mem_b_valid,
    input  wire logic                     mem_b_ready,
    input  wire emif_bridge_pkg::ar_req_t mem_ar,
    input  wire logic                     mem_ar_valid,
    input  wire logic                     mem_ar_ready,
    input  wire emif_bridge_pkg::r_beat_t mem_r,
    input  wire logic                     mem_r_valid,
    input  wire logic                     mem_r_ready,
    input  wire logic                     idle,
    output logic                          drained,
    output int                            data_errors,
    output int                            flow_errors
);
    import emif_bridge_pkg::*;

    // Expected payloads per channel as they enter the bridge
    aw_req_t aw_q[$];
    w_beat_t w_q[$];
    b_resp_t b_q[$];
    ar_req_t ar_q[$];
    r_beat_t r_q[$];

    // Model of outstanding writes and read bursts
    int   wr_cnt = 0;
    int   rd_cnt = 0;
    int   data_errs = 0;
    int   flow_errs = 0;
    logic all_empty = 1'b0;
    logic reset_seen = 1'b0;
    logic reset_checked = 1'b0;

    assign drained     = all_empty;
    assign data_errors = data_errs;
    assign flow_errors = flow_errs;

    task automatic compare_word(input string name, input logic [127:0] expected,
                                input logic [127:0] actual);
        if (actual !== expected) begin
            data_errs++;
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_flow(input string what);
        flow_errs++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // Input ready of one slice kind right after reset
    function automatic logic ready_after_reset(input logic [1:0] mode, input logic far_ready);
        if (mode == SLICE_BYPASS) begin
            return far_ready;
        end
        return 1'b1;
    endfunction

    // ------------------------------------------------------------------------
    // Sampled at the falling edge where inputs have settled
    // ------------------------------------------------------------------------
    always @(negedge s_if) begin : sample
        logic exp_idle;

        if (rst) begin
            reset_seen = 1'b1;
        end else begin
            if (reset_seen && !reset_checked) begin
                reset_checked = 1'b1;
                compare_word("mem_aw_valid", 128'(1'b0), 128'(mem_aw_valid));
                compare_word("mem_w_valid", 128'(1'b0), 128'(mem_w_valid));
                compare_word("mem_ar_valid", 128'(1'b0), 128'(mem_ar_valid));
                compare_word("usr_b_valid", 128'(1'b0), 128'(usr_b_valid));
                compare_word("usr_r_valid", 128'(1'b0), 128'(usr_r_valid));
                compare_word("usr_aw_ready", 128'(ready_after_reset(AW_MODE, mem_aw_ready)),
                             128'(usr_aw_ready));
                compare_word("usr_w_ready", 128'(ready_after_reset(W_MODE, mem_w_ready)),
                             128'(usr_w_ready));
                compare_word("mem_b_ready", 128'(ready_after_reset(B_MODE, usr_b_ready)),
                             128'(mem_b_ready));
                compare_word("usr_ar_ready", 128'(ready_after_reset(AR_MODE, mem_ar_ready)),
                             128'(usr_ar_ready));
                compare_word("mem_r_ready", 128'(ready_after_reset(R_MODE, usr_r_ready)),
                             128'(mem_r_ready));
            end

            // idle reflects transfers up to the last rising edge
            exp_idle = (wr_cnt == 0) && (rd_cnt == 0);
            compare_word("idle", 128'(exp_idle), 128'(idle));

            // Pushes go first since bypass slices move a payload in the same cycle
            if (usr_aw_valid && usr_aw_ready) aw_q.push_back(usr_aw);
            if (usr_w_valid && usr_w_ready) w_q.push_back(usr_w);
            if (mem_b_valid && mem_b_ready) b_q.push_back(mem_b);
            if (usr_ar_valid && usr_ar_ready) ar_q.push_back(usr_ar);
            if (mem_r_valid && mem_r_ready) r_q.push_back(mem_r);

            if (mem_aw_valid && mem_aw_ready) begin
                if (aw_q.size() == 0) report_flow("AW left the bridge but none was accepted");
                else compare_word("mem_aw", 128'(aw_q.pop_front()), 128'(mem_aw));
            end
            if (mem_w_valid && mem_w_ready) begin
                if (w_q.size() == 0) report_flow("W beat left the bridge but none was accepted");
                else compare_word("mem_w", 128'(w_q.pop_front()), 128'(mem_w));
            end
            if (usr_b_valid && usr_b_ready) begin
                if (b_q.size() == 0) report_flow("B left the bridge but none was accepted");
                else compare_word("usr_b", 128'(b_q.pop_front()), 128'(usr_b));
            end
            if (mem_ar_valid && mem_ar_ready) begin
                if (ar_q.size() == 0) report_flow("AR left the bridge but none was accepted");
                else compare_word("mem_ar", 128'(ar_q.pop_front()), 128'(mem_ar));
            end
            if (usr_r_valid && usr_r_ready) begin
                if (r_q.size() == 0) report_flow("R beat left the bridge but none was accepted");
                else compare_word("usr_r", 128'(r_q.pop_front()), 128'(usr_r));
            end

            if (usr_aw_valid && usr_aw_ready) wr_cnt++;
            if (usr_b_valid && usr_b_ready) wr_cnt--;
            if (usr_ar_valid && usr_ar_ready) rd_cnt++;
            if (usr_r_valid && usr_r_ready && usr_r.last) rd_cnt--;

            all_empty = (aw_q.size() == 0) && (w_q.size() == 0) && (b_q.size() == 0)
                && (ar_q.size() == 0) && (r_q.size() == 0) && (wr_cnt == 0) && (rd_cnt == 0);
        end
    end

endmodule

`default_nettype wire

// File: source/emif_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module emif_bridge (
    input  wire logic                     s_if,
    input  wire logic                     rst,
    // ------------------------------------------------------------------------
    // User side
    // ------------------------------------------------------------------------
    input  wire emif_bridge_pkg::aw_req_t usr_aw,
    input  wire logic                     usr_aw_valid,
    output logic                          usr_aw_ready,
    input  wire emif_bridge_pkg::w_beat_t usr_w,
    input  wire logic                     usr_w_valid,
    output logic                          usr_w_ready,
    output emif_bridge_pkg::b_resp_t      usr_b,
    output logic                          usr_b_valid,
    input  wire logic                     usr_b_ready,
    input  wire emif_bridge_pkg::ar_req_t usr_ar,
    input  wire logic                     usr_ar_valid,
    output logic                          usr_ar_ready,
    output emif_bridge_pkg::r_beat_t      usr_r,
    output logic                          usr_r_valid,
    input  wire logic                     usr_r_ready,
    // ------------------------------------------------------------------------
    // Memory controller side
    // ------------------------------------------------------------------------
    output emif_bridge_pkg::aw_req_t      mem_aw,
    output logic                          mem_aw_valid,
    input  wire logic                     mem_aw_ready,
    output emif_bridge_pkg::w_beat_t      mem_w,
    output logic                          mem_w_valid,
    input  wire logic                     mem_w_ready,
    input  wire emif_bridge_pkg::b_resp_t mem_b,
    input  wire logic                     mem_b_valid,
    output logic                          mem_b_ready,
    output emif_bridge_pkg::ar_req_t      mem_ar,
    output logic                          mem_ar_valid,
    input  wire logic                     mem_ar_ready,
    input  wire emif_bridge_pkg::r_beat_t mem_r,
    input  wire logic                     mem_r_valid,
    output logic                          mem_r_ready,
    // No write or read in flight
    output logic                          idle
);
    import emif_bridge_pkg::*;

    logic [CNT_WIDTH-1:0] wr_pending;
    logic [CNT_WIDTH-1:0] rd_pending;

    // Port names line up with the path modules
    emif_write_path u_write_path (.*);

    emif_read_path u_read_path (.*);

    assign idle = (wr_pending == '0) && (rd_pending == '0);

endmodule

`default_nettype wire

// File: source/emif_read_path.sv
`timescale 1ns/1ps
`default_nettype none

module emif_read_path (
    input  wire logic                     s_if,
    input  wire logic                     rst,
    // User side
    input  wire emif_bridge_pkg::ar_req_t usr_ar,
    input  wire logic                     usr_ar_valid,
    output logic                          usr_ar_ready,
    output emif_bridge_pkg::r_beat_t      usr_r,
    output logic                          usr_r_valid,
    input  wire logic                     usr_r_ready,
    // Memory side
    output emif_bridge_pkg::ar_req_t      mem_ar,
    output logic                          mem_ar_valid,
    input  wire logic                     mem_ar_ready,
    input  wire emif_bridge_pkg::r_beat_t mem_r,
    input  wire logic                     mem_r_valid,
    output logic                          mem_r_ready,
    output logic [emif_bridge_pkg::CNT_WIDTH-1:0] rd_pending
);
    import emif_bridge_pkg::*;

    logic ar_slice_ready;
    logic rd_full;
    logic ar_fire;
    logic r_done;

    assign rd_full      = (rd_pending == CNT_WIDTH'(MAX_OUTSTANDING));
    assign usr_ar_ready = ar_slice_ready && !rd_full;
    assign ar_fire      = usr_ar_valid && usr_ar_ready;
    // Burst retires on its last beat at the user side
    assign r_done       = usr_r_valid && usr_r_ready && usr_r.last;

    axi_reg_slice #(.MODE(AR_MODE), .WIDTH($bits(ar_req_t))) u_ar_slice (
        .s_if      (s_if),
        .rst       (rst),
        .in_valid  (usr_ar_valid && !rd_full),
        .in_ready  (ar_slice_ready),
        .in_data   (usr_ar),
        .out_valid (mem_ar_valid),
        .out_ready (mem_ar_ready),
        .out_data  (mem_ar)
    );

    axi_reg_slice #(.MODE(R_MODE), .WIDTH($bits(r_beat_t))) u_r_slice (
        .s_if      (s_if),
        .rst       (rst),
        .in_valid  (mem_r_valid),
        .in_ready  (mem_r_ready),
        .in_data   (mem_r),
        .out_valid (usr_r_valid),
        .out_ready (usr_r_ready),
        .out_data  (usr_r)
    );

    always_ff @(posedge s_if) begin
        if (rst) begin
            rd_pending <= '0;
        end else begin
            case ({ar_fire, r_done})
                2'b10:   rd_pending <= rd_pending + 1'b1;
                2'b01:   rd_pending <= rd_pending - 1'b1;
                default: rd_pending <= rd_pending;
            endcase
        end
    end

    // Memory must not return data for a burst that was never issued
    a_r_needs_ar : assert property (@(posedge s_if) disable iff (rst)
        mem_r_valid && mem_r_ready |-> rd_pending != '0)
        else $error("emif_read_path: R beat with no read outstanding");

endmodule

`default_nettype wire

// File: source/emif_write_path.sv
`timescale 1ns/1ps
`default_nettype none

module emif_write_path (
    input  wire logic                     s_if,
    input  wire logic                     rst,
    // User side
    input  wire emif_bridge_pkg::aw_req_t usr_aw,
    input  wire logic                     usr_aw_valid,
    output logic                          usr_aw_ready,
    input  wire emif_bridge_pkg::w_beat_t usr_w,
    input  wire logic                     usr_w_valid,
    output logic                          usr_w_ready,
    output emif_bridge_pkg::b_resp_t      usr_b,
    output logic                          usr_b_valid,
    input  wire logic                     usr_b_ready,
    // Memory side
    output emif_bridge_pkg::aw_req_t      mem_aw,
    output logic                          mem_aw_valid,
    input  wire logic                     mem_aw_ready,
    output emif_bridge_pkg::w_beat_t      mem_w,
    output logic                          mem_w_valid,
    input  wire logic                     mem_w_ready,
    input  wire emif_bridge_pkg::b_resp_t mem_b,
    input  wire logic                     mem_b_valid,
    output logic                          mem_b_ready,
    output logic [emif_bridge_pkg::CNT_WIDTH-1:0] wr_pending
);
    import emif_bridge_pkg::*;

    logic aw_slice_ready;
    logic wr_full;
    logic aw_fire;
    logic b_fire;

    // New writes are held off once the counter is at its limit
    assign wr_full      = (wr_pending == CNT_WIDTH'(MAX_OUTSTANDING));
    assign usr_aw_ready = aw_slice_ready && !wr_full;
    assign aw_fire      = usr_aw_valid && usr_aw_ready;
    assign b_fire       = usr_b_valid && usr_b_ready;

    axi_reg_slice #(.MODE(AW_MODE), .WIDTH($bits(aw_req_t))) u_aw_slice (
        .s_if      (s_if),
        .rst       (rst),
        .in_valid  (usr_aw_valid && !wr_full),
        .in_ready  (aw_slice_ready),
        .in_data   (usr_aw),
        .out_valid (mem_aw_valid),
        .out_ready (mem_aw_ready),
        .out_data  (mem_aw)
    );

    axi_reg_slice #(.MODE(W_MODE), .WIDTH($bits(w_beat_t))) u_w_slice (
        .s_if      (s_if),
        .rst       (rst),
        .in_valid  (usr_w_valid),
        .in_ready  (usr_w_ready),
        .in_data   (usr_w),
        .out_valid (mem_w_valid),
        .out_ready (mem_w_ready),
        .out_data  (mem_w)
    );

    // Response flows back toward the user
    axi_reg_slice #(.MODE(B_MODE), .WIDTH($bits(b_resp_t))) u_b_slice (
        .s_if      (s_if),
        .rst       (rst),
        .in_valid  (mem_b_valid),
        .in_ready  (mem_b_ready),
        .in_data   (mem_b),
        .out_valid (usr_b_valid),
        .out_ready (usr_b_ready),
        .out_data  (usr_b)
    );

    // Outstanding writes, AW in at user side, B out at user side
    always_ff @(posedge s_if) begin
        if (rst) begin
            wr_pending <= '0;
        end else begin
            case ({aw_fire, b_fire})
                2'b10:   wr_pending <= wr_pending + 1'b1;
                2'b01:   wr_pending <= wr_pending - 1'b1;
                default: wr_pending <= wr_pending;
            endcase
        end
    end

    a_b_needs_aw : assert property (@(posedge s_if) disable iff (rst)
        b_fire |-> wr_pending != '0)
        else $error("emif_write_path: B response with no write outstanding");

endmodule

`default_nettype wire

// File: source/axi_reg_slice.sv
`timescale 1ns/1ps
`default_nettype none

module axi_reg_slice #(
    parameter logic [1:0] MODE  = emif_bridge_pkg::SLICE_SKID,
    parameter int         WIDTH = 32
) (
    input  wire logic             s_if,
    input  wire logic             rst,
    input  wire logic             in_valid,
    output logic                  in_ready,
    input  wire logic [WIDTH-1:0] in_data,
    output logic                  out_valid,
    input  wire logic             out_ready,
    output logic      [WIDTH-1:0] out_data
);
    import emif_bridge_pkg::*;

    generate
        if (MODE == SLICE_SKID) begin : g_skid
            logic             main_valid;
            logic [WIDTH-1:0] main_data;
            logic             skid_valid;
            logic [WIDTH-1:0] skid_data;
            logic             load_main;

            // Main register is empty or drains this cycle
            assign load_main = !main_valid || out_ready;

            always_ff @(posedge s_if) begin
                if (rst) begin
                    main_valid <= 1'b0;
                    skid_valid <= 1'b0;
                end else if (load_main) begin
                    // Skid entry is older, it goes first
                    main_valid <= skid_valid || in_valid;
                    skid_valid <= 1'b0;
                end else if (in_valid && !skid_valid) begin
                    skid_valid <= 1'b1;
                end
            end

            always_ff @(posedge s_if) begin
                if (load_main) begin
                    main_data <= skid_valid ? skid_data : in_data;
                end
                if (!load_main && !skid_valid) begin
                    skid_data <= in_data;
                end
            end

            // Registered ready, drops only while the skid entry is held
            assign in_ready  = !skid_valid;
            assign out_valid = main_valid;
            assign out_data  = main_data;
        end else if (MODE == SLICE_SIMPLE) begin : g_simple
            logic             full;
            logic [WIDTH-1:0] data_q;

            always_ff @(posedge s_if) begin
                if (rst) begin
                    full <= 1'b0;
                end else if (!full) begin
                    full <= in_valid;
                end else if (out_ready) begin
                    full <= 1'b0;
                end
            end

            always_ff @(posedge s_if) begin
                if (!full) begin
                    data_q <= in_data;
                end
            end

            // One slot, so never accepts and drains in the same cycle
            assign in_ready  = !full;
            assign out_valid = full;
            assign out_data  = data_q;
        end else begin : g_bypass
            // SLICE_BYPASS, straight wires with no latency
            assign in_ready  = out_ready;
            assign out_valid = in_valid;
            assign out_data  = in_data;
        end
    endgenerate

    // Stalled output holds its payload until taken
    property p_out_hold;
        @(posedge s_if) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data);
    endproperty

    a_out_hold : assert property (p_out_hold)
        else $error("axi_reg_slice: out_data changed while stalled");

endmodule

`default_nettype wire

// File: source/emif_bridge_pkg.sv
`default_nettype none

package emif_bridge_pkg;

    // ------------------------------------------------------------------------
    // AXI field widths
    // ------------------------------------------------------------------------
    localparam int ID_WIDTH   = 9;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 64;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int USER_WIDTH = 4;

    // ------------------------------------------------------------------------
    // Register slice kinds and per-channel choice
    // ------------------------------------------------------------------------
    localparam logic [1:0] SLICE_SKID   = 2'd0;
    localparam logic [1:0] SLICE_SIMPLE = 2'd1;
    localparam logic [1:0] SLICE_BYPASS = 2'd2;

    localparam logic [1:0] AW_MODE = SLICE_SKID;
    localparam logic [1:0] W_MODE  = SLICE_BYPASS;
    localparam logic [1:0] B_MODE  = SLICE_SIMPLE;
    localparam logic [1:0] AR_MODE = SLICE_SIMPLE;
    localparam logic [1:0] R_MODE  = SLICE_BYPASS;

    // Outstanding transaction limit, counters hold 0..MAX_OUTSTANDING
    localparam int MAX_OUTSTANDING = 16;
    localparam int CNT_WIDTH       = $clog2(MAX_OUTSTANDING + 1);

    // ------------------------------------------------------------------------
    // Channel payloads
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic                  lock;
        logic [3:0]            cache;
        logic [2:0]            prot;
        logic [USER_WIDTH-1:0] user;
    } aw_req_t;

    // Read address carries the same fields as write address
    typedef aw_req_t ar_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } w_beat_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [1:0]            resp;
        logic [USER_WIDTH-1:0] user;
    } b_resp_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
        logic                  last;
        logic [USER_WIDTH-1:0] user;
    } r_beat_t;

endpackage

`default_nettype wire
